// File: design/cpu_pkg.sv
package cpu_pkg;

	typedef logic [15:0] word_t; // one data/address word

	// instr[15:12]
	typedef enum logic [3:0] {
		ADD   = 4'h0,
		ADDI  = 4'h1,
		SUB   = 4'h2,
		SUBI  = 4'h3,
		AND   = 4'h4,
		OR    = 4'h5,
		XOR   = 4'h6,
		MOV   = 4'h7,
		MOVI  = 4'h8,
		CMP   = 4'h9,
		LOAD  = 4'hA,
		STOR  = 4'hB,
		BCOND = 4'hC,
		JCOND = 4'hD,
		HALT  = 4'hF
	} opcode_e;

	// instr[11:8] for bcond/jcond, unlisted codes never taken
	typedef enum logic [3:0] {
		EQ = 4'h0,
		NE = 4'h1,
		LO = 4'h2,
		HS = 4'h3,
		LT = 4'h4,
		GE = 4'h5,
		AL = 4'hE
	} cond_e;

	typedef struct packed {
		logic c; // carry out / unsigned borrow
		logic l; // rdest below source, unsigned
		logic f; // signed overflow
		logic z; // zero
		logic n; // negative
	} flags_t;

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXEC,
		MEM,
		HALTED
	} state_e;

	typedef struct packed {
		logic       pc_en;       // advance pc this cycle
		logic       pc_sel_jump; // register target instead of displacement
		logic       pc_load;     // branch/jump taken
		logic       ls_sel;      // port a address from rsrc, else pc
		logic       mem_we;
		logic       imm_sel;     // alu b from immediate
		logic       wb_sel_mem;  // writeback from q_a
		logic       reg_we;
		opcode_e    op;
		logic [3:0] rdest;
		logic [3:0] rsrc;
		logic [7:0] imm;  // zero-extended at the mux
		logic [7:0] disp; // sign-extended in the pc
		flags_t     flags; // stored flags, alu passes these through
	} ctrl_t;

	function automatic logic updates_flags(opcode_e op);
		return op inside {ADD, ADDI, SUB, SUBI, CMP};
	endfunction

	function automatic logic writes_reg(opcode_e op);
		return op inside {ADD, ADDI, SUB, SUBI, AND, OR, XOR, MOV, MOVI};
	endfunction

	function automatic logic uses_imm(opcode_e op);
		return op inside {ADDI, SUBI, MOVI};
	endfunction

	// condition against stored flags
	function automatic logic cond_taken(cond_e cond, flags_t fl);
		case (cond)
			EQ: return fl.z;
			NE: return !fl.z;
			LO: return fl.c;
			HS: return !fl.c;
			LT: return fl.n;
			GE: return !fl.n;
			AL: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

endpackage

// File: design/dual_port_ram.sv
`timescale 1ns/100ps
module dual_port_ram #(
	parameter int ADDR_W = 10
) (
	input  logic              clk,
	input  cpu_pkg::word_t    data_a,
	input  cpu_pkg::word_t    data_b,
	input  logic [ADDR_W-1:0] addr_a,
	input  logic [ADDR_W-1:0] addr_b,
	input  logic              we_a,
	input  logic              we_b,
	output cpu_pkg::word_t    q_a,
	output cpu_pkg::word_t    q_b
);
	import cpu_pkg::*;

	word_t mem [2**ADDR_W]; // no reset, port b usable during cpu reset

	// both ports in one process, read-first on each
	always_ff @(posedge clk) begin
		if (we_a) begin
			mem[addr_a] <= data_a;
		end
		if (we_b) begin
			mem[addr_b] <= data_b; // same-address collision undefined
		end
		q_a <= mem[addr_a]; // old word on a write
		q_b <= mem[addr_b];
	end

endmodule

// File: design/program_counter.sv
`timescale 1ns/100ps
module program_counter (
	input  logic           clk,
	input  logic           reset,
	input  logic           en,
	input  logic           jump, // register target over displacement
	input  logic           load, // taken branch
	input  logic [7:0]     disp,
	input  cpu_pkg::word_t tgt_addr,
	output cpu_pkg::word_t pc
);
	import cpu_pkg::*;

	word_t disp_ext;
	word_t pc_nxt;

	assign disp_ext = {{8{disp[7]}}, disp}; // signed displacement

	always_comb begin
		pc_nxt = pc + 16'd1; // default step
		if (load) begin
			if (jump) begin
				pc_nxt = tgt_addr;
			end else begin
				pc_nxt = pc + 16'd1 + disp_ext; // relative to next instr
			end
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pc <= '0;
		end else if (en) begin
			pc <= pc_nxt;
		end
	end

endmodule

// File: design/control_decoder.sv
`timescale 1ns/100ps
module control_decoder (
	input  logic            clk,
	input  logic            reset,
	input  cpu_pkg::word_t  instr,      // q_a of port a
	input  cpu_pkg::flags_t flags_next, // from alu
	output cpu_pkg::ctrl_t  ctrl,
	output logic            halted
);
	import cpu_pkg::*;

	state_e  state;
	state_e  state_nxt;
	word_t   ir;
	flags_t  flags; // stored flags
	opcode_e op;
	cond_e   cond;
	logic    taken;

	assign op    = opcode_e'(ir[15:12]);
	assign cond  = cond_e'(ir[11:8]); // shares the rdest field
	assign taken = cond_taken(cond, flags);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= FETCH;
		end else begin
			state <= state_nxt;
		end
	end

	// ir picks up the fetched word one cycle after fetch
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			ir <= '0;
		end else if (state == DECODE) begin
			ir <= instr;
		end
	end

	// flags only move when an arithmetic op or cmp retires
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			flags <= '0;
		end else if (state == EXEC && updates_flags(op)) begin
			flags <= flags_next;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			FETCH:  state_nxt = DECODE;
			DECODE: state_nxt = EXEC;
			EXEC: begin
				if (op == LOAD) begin
					state_nxt = MEM; // extra cycle for read data
				end else if (op == HALT) begin
					state_nxt = HALTED;
				end else begin
					state_nxt = FETCH;
				end
			end
			MEM:     state_nxt = FETCH;
			HALTED:  state_nxt = HALTED; // sticky until reset
			default: state_nxt = FETCH;
		endcase
	end

	always_comb begin
		ctrl         = '0;
		ctrl.op      = op;
		ctrl.rdest   = ir[11:8];
		ctrl.rsrc    = ir[7:4];
		ctrl.imm     = ir[7:0];
		ctrl.disp    = ir[7:0];
		ctrl.flags   = flags;
		ctrl.imm_sel = uses_imm(op); // operand select only
		case (state)
			EXEC: begin
				ctrl.pc_en  = (op != LOAD); // load advances in MEM
				ctrl.reg_we = writes_reg(op);
				ctrl.mem_we = (op == STOR);
				ctrl.ls_sel = (op == LOAD) || (op == STOR);
				if (op == BCOND || op == JCOND) begin
					ctrl.pc_load     = taken;
					ctrl.pc_sel_jump = (op == JCOND);
				end
			end
			MEM: begin
				ctrl.pc_en      = 1'b1;
				ctrl.reg_we     = 1'b1;
				ctrl.wb_sel_mem = 1'b1; // q_a holds the loaded word
			end
			default: ; // fetch, decode, halted drive no enables
		endcase
	end

	assign halted = (state == HALTED);

endmodule

// File: design/regfile.sv
`timescale 1ns/100ps
module regfile (
	input  logic           clk,
	input  logic           reset,
	input  logic           we,
	input  logic [3:0]     waddr,
	input  logic [3:0]     raddr_a,
	input  logic [3:0]     raddr_b,
	input  cpu_pkg::word_t wdata,
	output cpu_pkg::word_t rdata_a,
	output cpu_pkg::word_t rdata_b,
	output cpu_pkg::word_t last_wdata // most recent write, shown on out
);
	import cpu_pkg::*;

	word_t regs [16];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
			last_wdata <= '0;
		end else if (we) begin
			regs[waddr] <= wdata;
			last_wdata  <= wdata;
		end
	end

	// async reads
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

endmodule

// File: design/alu.sv
`timescale 1ns/100ps
module alu (
	input  cpu_pkg::word_t  a, // rdest
	input  cpu_pkg::word_t  b, // rsrc or immediate
	input  cpu_pkg::opcode_e op,
	input  cpu_pkg::flags_t flags_in,
	output cpu_pkg::word_t  result,
	output cpu_pkg::flags_t flags_out
);
	import cpu_pkg::*;

	logic [16:0] sum; // bit 16 is carry out
	word_t       diff;
	logic        add_ovf;
	logic        sub_ovf;

	assign sum     = {1'b0, a} + {1'b0, b};
	assign diff    = a - b;
	assign add_ovf = (a[15] == b[15]) && (sum[15] != a[15]);
	assign sub_ovf = (a[15] != b[15]) && (diff[15] != a[15]);

	always_comb begin
		result    = '0;
		flags_out = flags_in; // untouched unless arithmetic
		case (op)
			ADD, ADDI: begin
				result      = sum[15:0];
				flags_out.c = sum[16];
				flags_out.f = add_ovf;
			end
			SUB, SUBI, CMP: begin
				result      = diff;
				flags_out.c = (a < b); // borrow
				flags_out.f = sub_ovf;
			end
			AND:       result = a & b;
			OR:        result = a | b;
			XOR:       result = a ^ b;
			MOV, MOVI: result = b;
			default:   result = '0;
		endcase
		if (updates_flags(op)) begin
			flags_out.l = (a < b);
			flags_out.z = (result == '0);
			flags_out.n = result[15];
		end
		if (op == CMP) begin
			result = '0; // flags only
		end
	end

endmodule

// File: design/cpu_top.sv
`timescale 1ns/100ps
module cpu_top #(
	parameter int ADDR_W = 10 // ram depth is 2**ADDR_W words
) (
	input  logic              clk,
	input  logic              reset,
	input  logic [ADDR_W-1:0] ext_addr,  // port b, program load / readback
	input  cpu_pkg::word_t    ext_wdata,
	input  logic              ext_we,
	output cpu_pkg::word_t    ext_rdata,
	output cpu_pkg::word_t    out,       // last register write
	output logic              halted
);
	import cpu_pkg::*;

	ctrl_t             ctrl;
	flags_t            flags_next;
	word_t             pc;
	word_t             q_a;
	word_t             rdata_a; // rdest
	word_t             rdata_b; // rsrc
	word_t             alu_b;
	word_t             alu_out;
	word_t             wb_data;
	word_t             mem_addr;
	logic [ADDR_W-1:0] addr_a;

	// port a address, pc on fetch, rsrc for load/store
	assign mem_addr = ctrl.ls_sel ? rdata_b : pc;
	assign addr_a   = mem_addr[ADDR_W-1:0]; // wraps modulo depth

	assign alu_b   = ctrl.imm_sel ? {8'h00, ctrl.imm} : rdata_b;
	assign wb_data = ctrl.wb_sel_mem ? q_a : alu_out;

	dual_port_ram #(
		.ADDR_W(ADDR_W)
	) u_ram (
		.clk   (clk),
		.data_a(rdata_a), // store data from rdest
		.data_b(ext_wdata),
		.addr_a(addr_a),
		.addr_b(ext_addr),
		.we_a  (ctrl.mem_we),
		.we_b  (ext_we),
		.q_a   (q_a),
		.q_b   (ext_rdata)
	);

	program_counter u_pc (
		.clk     (clk),
		.reset   (reset),
		.en      (ctrl.pc_en),
		.jump    (ctrl.pc_sel_jump),
		.load    (ctrl.pc_load),
		.disp    (ctrl.disp),
		.tgt_addr(rdata_b), // jcond target in rsrc
		.pc      (pc)
	);

	control_decoder u_ctrl (
		.clk       (clk),
		.reset     (reset),
		.instr     (q_a),
		.flags_next(flags_next),
		.ctrl      (ctrl),
		.halted    (halted)
	);

	regfile u_regs (
		.clk       (clk),
		.reset     (reset),
		.we        (ctrl.reg_we),
		.waddr     (ctrl.rdest),
		.raddr_a   (ctrl.rdest),
		.raddr_b   (ctrl.rsrc),
		.wdata     (wb_data),
		.rdata_a   (rdata_a),
		.rdata_b   (rdata_b),
		.last_wdata(out)
	);

	alu u_alu (
		.a        (rdata_a),
		.b        (alu_b),
		.op       (ctrl.op),
		.flags_in (ctrl.flags),
		.result   (alu_out),
		.flags_out(flags_next)
	);

endmodule

// File: dv/cpu_assert.sv
`timescale 1ns/100ps
module cpu_assert (
	input logic           clk,
	input logic           reset,
	input cpu_pkg::ctrl_t ctrl,
	input logic           halted
);
	import cpu_pkg::*;

	logic pc_en;
	logic any_we; // every enable that changes core state

	assign pc_en  = ctrl.pc_en;
	assign any_we = ctrl.mem_we | ctrl.reg_we | ctrl.pc_en;

	// one pc step per instruction, never back to back
	pc_en_single: assert property (@(posedge clk) disable iff (!reset)
		$past(pc_en) |-> !pc_en)
		else $error("pc_en high in two consecutive cycles");

	halted_sticky: assert property (@(posedge clk) disable iff (!reset)
		$past(halted) |-> halted)
		else $error("halted fell while out of reset");

	// store and writeback share no cycle
	we_exclusive: assert property (@(posedge clk) disable iff (!reset)
		!(ctrl.mem_we && ctrl.reg_we))
		else $error("mem_we and reg_we high together");

	halted_quiet: assert property (@(posedge clk) disable iff (!reset)
		halted |-> !any_we)
		else $error("write enable asserted after halt");

endmodule

bind cpu_top cpu_assert u_assert (
	.clk   (clk),
	.reset (reset),
	.ctrl  (ctrl),
	.halted(halted)
);

// File: dv/cpu_tb.sv
`timescale 1ns/100ps
module cpu_tb;
	import cpu_pkg::*;

	localparam int ADDR_W       = 10;
	localparam int HALT_TIMEOUT = 2000; // cycles

	logic              clk;
	logic              reset;
	logic [ADDR_W-1:0] ext_addr;
	word_t             ext_wdata;
	logic              ext_we;
	word_t             ext_rdata;
	word_t             out;
	logic              halted;

	logic [31:0] lfsr = 32'he9fd_5a17;
	word_t       prog [$]; // image for the next run, loaded at 0
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          errors_before = 0;

	cpu_top #(
		.ADDR_W(ADDR_W)
	) dut (
		.clk      (clk),
		.reset    (reset),
		.ext_addr (ext_addr),
		.ext_wdata(ext_wdata),
		.ext_we   (ext_we),
		.ext_rdata(ext_rdata),
		.out      (out),
		.halted   (halted)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	// x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic word_t rand_bits(int n);
		word_t v;
		logic  fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[14:0], fb};
		end
		return v;
	endfunction

	function automatic word_t reg_instr(opcode_e op, logic [3:0] rd, logic [3:0] rs);
		return {op, rd, rs, 4'h0};
	endfunction

	function automatic word_t imm_instr(opcode_e op, logic [3:0] rd, logic [7:0] imm);
		return {op, rd, imm}; // also cond + disp for bcond
	endfunction

	// reference branch decision after cmp a, b
	function automatic logic expect_taken(logic [3:0] cond, word_t a, word_t b);
		word_t diff;
		diff = a - b;
		case (cond)
			4'h0:    return a == b;
			4'h1:    return a != b;
			4'h2:    return a < b; // unsigned borrow
			4'h3:    return a >= b;
			4'h4:    return diff[15];
			4'h5:    return !diff[15];
			4'hE:    return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	task automatic write_word(int addr, word_t data);
		@(posedge clk);
		ext_addr  <= addr[ADDR_W-1:0];
		ext_wdata <= data;
		ext_we    <= 1'b1;
		@(posedge clk);
		ext_we    <= 1'b0;
	endtask

	task automatic check_word(int addr, word_t exp);
		@(posedge clk);
		ext_addr <= addr[ADDR_W-1:0];
		@(posedge clk); // ram latches address
		@(negedge clk);
		checks++;
		assert (ext_rdata == exp) else begin
			$display("Fail ext_rdata[%h]: expected %h, actual %h", addr, exp, ext_rdata);
			errors++;
		end
	endtask

	task automatic hold_reset();
		@(posedge clk);
		reset <= 1'b0;
		repeat (16) @(posedge clk);
	endtask

	task automatic run_program(string name);
		int cyc;
		foreach (prog[i]) begin
			write_word(i, prog[i]); // core still in reset
		end
		prog.delete();
		@(posedge clk);
		reset <= 1'b1;
		cyc = 0;
		@(negedge clk);
		while (!halted && cyc < HALT_TIMEOUT) begin
			@(negedge clk);
			cyc++;
		end
		if (!halted) begin
			$display("timeout in %s, halted still low after %0d cycles", name, HALT_TIMEOUT);
			errors++;
		end
	endtask

	task automatic finish_test(string name);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == errors_before) ? "ok" : "errors");
		errors_before = errors;
	endtask

	task automatic reg_ops_test();
		opcode_e ops [6] = '{ADD, SUB, AND, OR, XOR, MOV};
		word_t   a;
		word_t   b;
		word_t   exp [6];
		hold_reset();
		a   = rand_bits(8);
		b   = rand_bits(8);
		exp = '{a + b, a - b, a & b, a | b, a ^ b, b};
		prog.push_back(imm_instr(MOVI, 4'd2, b[7:0]));
		for (int i = 0; i < 6; i++) begin
			prog.push_back(imm_instr(MOVI, 4'd9, 8'h80 + i[7:0])); // result address
			prog.push_back(imm_instr(MOVI, 4'd3, a[7:0]));
			prog.push_back(reg_instr(ops[i], 4'd3, 4'd2));
			prog.push_back(reg_instr(STOR, 4'd3, 4'd9));
		end
		prog.push_back(reg_instr(HALT, 4'd0, 4'd0));
		run_program("reg_ops");
		for (int i = 0; i < 6; i++) begin
			check_word(8'h80 + i, exp[i]);
		end
		checks++;
		assert (out == b) else begin // mov result written last
			$display("Fail out: expected %h, actual %h", b, out);
			errors++;
		end
		finish_test("reg_ops");
	endtask

	task automatic imm_ops_test();
		word_t x;
		word_t s;
		word_t imm [4];
		word_t exp [4];
		hold_reset();
		x      = rand_bits(8);
		s      = rand_bits(4);
		imm[0] = rand_bits(8);
		imm[1] = rand_bits(8);
		imm[2] = rand_bits(7) | 16'h0080; // above s, wraps below zero
		imm[3] = rand_bits(7) | 16'h0080;
		exp[0] = x + imm[0];
		exp[1] = exp[0] - imm[1];
		exp[2] = s - imm[2];
		exp[3] = exp[2] + imm[3];
		prog = '{imm_instr(MOVI, 4'd9, 8'h90), imm_instr(MOVI, 4'd4, x[7:0]),
			imm_instr(ADDI, 4'd4, imm[0][7:0]), reg_instr(STOR, 4'd4, 4'd9),
			imm_instr(ADDI, 4'd9, 8'd1), imm_instr(SUBI, 4'd4, imm[1][7:0]),
			reg_instr(STOR, 4'd4, 4'd9), imm_instr(ADDI, 4'd9, 8'd1),
			imm_instr(MOVI, 4'd5, s[7:0]), imm_instr(SUBI, 4'd5, imm[2][7:0]),
			reg_instr(STOR, 4'd5, 4'd9), imm_instr(ADDI, 4'd9, 8'd1),
			imm_instr(ADDI, 4'd5, imm[3][7:0]), reg_instr(STOR, 4'd5, 4'd9),
			reg_instr(HALT, 4'd0, 4'd0)};
		run_program("imm_ops");
		for (int i = 0; i < 4; i++) begin
			check_word(8'h90 + i, exp[i]);
		end
		finish_test("imm_ops");
	endtask

	task automatic load_store_test();
		word_t d [3];
		hold_reset();
		for (int i = 0; i < 3; i++) begin
			d[i] = rand_bits(16);
			write_word(8'hA0 + i, d[i]); // data words through port b
		end
		prog = '{imm_instr(MOVI, 4'd1, 8'hA0), reg_instr(LOAD, 4'd2, 4'd1),
			imm_instr(MOVI, 4'd1, 8'hA1), reg_instr(LOAD, 4'd3, 4'd1),
			reg_instr(ADD, 4'd2, 4'd3), imm_instr(MOVI, 4'd1, 8'hA2),
			reg_instr(LOAD, 4'd4, 4'd1), reg_instr(ADD, 4'd2, 4'd4), // uses load at once
			imm_instr(MOVI, 4'd6, 8'hB0), reg_instr(STOR, 4'd2, 4'd6),
			imm_instr(MOVI, 4'd6, 8'hB1), reg_instr(STOR, 4'd4, 4'd6),
			reg_instr(HALT, 4'd0, 4'd0)};
		run_program("load_store");
		check_word(8'hB0, d[0] + d[1] + d[2]);
		check_word(8'hB1, d[2]);
		finish_test("load_store");
	endtask

	task automatic branch_test();
		logic [3:0] conds [8] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hE, 4'h7};
		word_t      ax;
		word_t      ay;
		word_t      bx;
		word_t      by;
		word_t      a;
		word_t      b;
		logic [7:0] mark_t;
		logic [7:0] mark_n;
		word_t      exp [8];
		hold_reset();
		for (int i = 0; i < 8; i++) begin
			ax = rand_bits(8);
			ay = rand_bits(8);
			bx = rand_bits(8);
			by = rand_bits(8);
			if (rand_bits(1)) begin // equal pairs now and then
				bx = ax;
				by = ay;
			end
			a      = ax - ay; // both signs, so n and c can differ
			b      = bx - by;
			mark_t = 8'h80 | i[7:0];
			mark_n = 8'h40 | i[7:0];
			exp[i] = {8'h00, expect_taken(conds[i], a, b) ? mark_t : mark_n};
			prog.push_back(imm_instr(MOVI, 4'd1, ax[7:0]));
			prog.push_back(imm_instr(SUBI, 4'd1, ay[7:0]));
			prog.push_back(imm_instr(MOVI, 4'd2, bx[7:0]));
			prog.push_back(imm_instr(SUBI, 4'd2, by[7:0]));
			prog.push_back(imm_instr(MOVI, 4'd9, 8'hD0 + i[7:0]));
			prog.push_back(reg_instr(CMP, 4'd1, 4'd2));
			prog.push_back(imm_instr(BCOND, conds[i], 8'd2)); // to taken marker
			prog.push_back(imm_instr(MOVI, 4'd5, mark_n));
			prog.push_back(imm_instr(BCOND, 4'hE, 8'd1)); // over taken marker
			prog.push_back(imm_instr(MOVI, 4'd5, mark_t));
			prog.push_back(reg_instr(STOR, 4'd5, 4'd9));
		end
		prog.push_back(reg_instr(HALT, 4'd0, 4'd0));
		run_program("branches");
		for (int i = 0; i < 8; i++) begin
			check_word(8'hD0 + i, exp[i]);
		end
		finish_test("branches");
	endtask

	task automatic jump_halt_test();
		word_t pre;
		hold_reset();
		pre = rand_bits(16);
		write_word(8'hC0, pre);
		write_word(8'hC1, 16'h0000);
		prog = '{imm_instr(MOVI, 4'd8, 8'd6), imm_instr(MOVI, 4'd9, 8'hC0),
			imm_instr(MOVI, 4'd5, 8'h5A), reg_instr(JCOND, 4'hE, 4'd8),
			reg_instr(STOR, 4'd5, 4'd9), reg_instr(HALT, 4'd0, 4'd0), // skipped
			imm_instr(MOVI, 4'd9, 8'hC1), reg_instr(STOR, 4'd5, 4'd9),
			reg_instr(HALT, 4'd0, 4'd0)};
		run_program("jump_halt");
		check_word(8'hC0, pre);
		check_word(8'hC1, 16'h005A);
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			checks++;
			assert (halted) else begin
				$display("Fail halted: expected 1, actual %h", halted);
				errors++;
			end
		end
		finish_test("jump_halt");
	endtask

	initial begin
		reset     = 1'b0;
		ext_addr  = '0;
		ext_wdata = '0;
		ext_we    = 1'b0;
		reg_ops_test();
		imm_ops_test();
		load_store_test();
		branch_test();
		jump_halt_test();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: cpu_top.f
design/cpu_pkg.sv
design/dual_port_ram.sv
design/program_counter.sv
design/control_decoder.sv
design/regfile.sv
design/alu.sv
design/cpu_top.sv
dv/cpu_assert.sv
dv/cpu_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the cpu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cpu_tb -f cpu_top.f -o cpu_sim
./obj_dir/cpu_sim > sim.log 2>&1

if grep -q "TB FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"
